//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;  // addi x0, x0, 0

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_LT} br_type_t;

    // Operand source in execute
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_t;

    typedef struct packed {
        logic     rf_we;
        logic     mem_we;
        logic     mem_re;
        logic     alu_src1_pc;
        logic     alu_src2_imm;
        alu_op_t  alu_op;
        wb_sel_t  wb_sel;
        br_type_t br_type;
        logic     jal;
        logic     jalr;
    } ctrl_t;

    localparam ctrl_t CTRL_BUBBLE = '0;  // No writes, no transfer

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus4;
        logic [XLEN-1:0] insn;
    } if_id_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        ctrl_t                 ctrl;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       alu;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        logic                  mem_we;
        logic                  mem_re;
        wb_sel_t               wb_sel;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc_plus4;
        logic [XLEN-1:0]       alu;
        logic [XLEN-1:0]       load_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rf_we;
        wb_sel_t               wb_sel;
    } mem_wb_t;

endpackage

`default_nettype wire

//--- logic/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t bubble,
    input  payload_t d,
    output payload_t q
);

    // Flush wins over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= bubble;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- logic/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder import cpu_pkg::*; (
    input  logic [XLEN-1:0] insn,
    output ctrl_t           ctrl,
    output logic [XLEN-1:0] imm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    assign opcode = insn[6:0];
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_u = {insn[31:12], 12'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        ctrl = CTRL_BUBBLE;
        imm  = '0;
        case (opcode)
            OPC_OP: begin
                ctrl.rf_we = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b010:  ctrl.alu_op = ALU_SLT;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl = CTRL_BUBBLE;   // sltu
                endcase
                // Only sub may set funct7, so sra falls out here
                if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
                    ctrl = CTRL_BUBBLE;
                end
            end
            OPC_OP_IMM: begin
                ctrl.rf_we        = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                imm               = imm_i;
                case (funct3)
                    3'b000:  ctrl.alu_op = ALU_ADD;
                    3'b001:  ctrl.alu_op = ALU_SLL;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b101:  ctrl.alu_op = ALU_SRL;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl = CTRL_BUBBLE;   // slti, sltiu
                endcase
                if (funct3[1:0] == 2'b01 && funct7 != 7'b0) begin
                    ctrl = CTRL_BUBBLE;  // srai
                end
            end
            OPC_LUI: begin
                ctrl.rf_we        = 1'b1;
                ctrl.alu_src1_pc  = 1'b1;  // Marks rs1 as unused
                ctrl.alu_src2_imm = 1'b1;
                ctrl.alu_op       = ALU_PASS_B;
                imm               = imm_u;
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.mem_re       = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    ctrl.wb_sel       = WB_MEM;
                    imm               = imm_i;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    ctrl.mem_we       = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    imm               = imm_s;
                end
            end
            OPC_BRANCH: begin
                ctrl.alu_src1_pc  = 1'b1;  // ALU forms the target
                ctrl.alu_src2_imm = 1'b1;
                imm               = imm_b;
                case (funct3)
                    3'b000:  ctrl.br_type = BR_EQ;
                    3'b001:  ctrl.br_type = BR_NE;
                    3'b100:  ctrl.br_type = BR_LT;
                    default: ctrl = CTRL_BUBBLE;
                endcase
            end
            OPC_JAL: begin
                ctrl.rf_we        = 1'b1;
                ctrl.jal          = 1'b1;
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.wb_sel       = WB_PC4;
                imm               = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl.rf_we        = 1'b1;
                    ctrl.jalr         = 1'b1;
                    ctrl.alu_src2_imm = 1'b1;
                    ctrl.wb_sel       = WB_PC4;
                    imm               = imm_i;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic                  rd_we,
    input  logic [XLEN-1:0]       rd_data,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data,
    input  logic [REG_ADDR_W-1:0] debug_addr,
    output logic [XLEN-1:0]       debug_data
);

    logic [XLEN-1:0] regs [32];

    // Write-first read, x0 reads zero
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (rd_we && rd_addr == addr) begin
            return rd_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    assign rs1_data   = read_port(rs1_addr);
    assign rs2_data   = read_port(rs2_addr);
    assign debug_data = regs[debug_addr];  // x0 is never written

endmodule

`default_nettype wire

//--- logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit import cpu_pkg::*; (
    input  logic [REG_ADDR_W-1:0] ex_rs1,
    input  logic [REG_ADDR_W-1:0] ex_rs2,
    input  logic                  ex_rs1_used,
    input  logic                  ex_rs2_used,
    input  logic [REG_ADDR_W-1:0] ex_rd,
    input  logic                  ex_is_load,
    input  logic [REG_ADDR_W-1:0] mem_rd,
    input  logic                  mem_rf_we,
    input  logic                  mem_is_load,
    input  logic [REG_ADDR_W-1:0] wb_rd,
    input  logic                  wb_rf_we,
    input  logic [REG_ADDR_W-1:0] id_rs1,
    input  logic [REG_ADDR_W-1:0] id_rs2,
    input  logic                  redirect,
    output fwd_sel_t              fwd1_sel,
    output fwd_sel_t              fwd2_sel,
    output logic                  pc_stall,
    output logic                  if_id_stall,
    output logic                  if_id_flush,
    output logic                  id_ex_flush
);

    logic load_use;

    // Younger result wins
    function automatic fwd_sel_t pick(input logic [REG_ADDR_W-1:0] rs, input logic used);
        if (!used || rs == '0) begin
            return FWD_NONE;
        end
        if (mem_rf_we && !mem_is_load && mem_rd == rs) begin
            return FWD_MEM;  // Load data not ready here
        end
        if (wb_rf_we && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    assign fwd1_sel = pick(ex_rs1, ex_rs1_used);
    assign fwd2_sel = pick(ex_rs2, ex_rs2_used);

    assign load_use = ex_is_load && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign pc_stall    = load_use && !redirect;
    assign if_id_stall = load_use && !redirect;
    assign if_id_flush = redirect;
    assign id_ex_flush = redirect || load_use;  // Bubble behind the load

endmodule

`default_nettype wire

//--- logic/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute import cpu_pkg::*; (
    input  id_ex_t          id_ex,
    input  fwd_sel_t        fwd1_sel,
    input  fwd_sel_t        fwd2_sel,
    input  logic [XLEN-1:0] mem_fwd_data,
    input  logic [XLEN-1:0] wb_fwd_data,
    output logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] store_data,
    output logic            redirect,
    output logic [XLEN-1:0] redirect_pc
);

    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            taken;

    assign op1 = (fwd1_sel == FWD_MEM) ? mem_fwd_data :
                 (fwd1_sel == FWD_WB)  ? wb_fwd_data  : id_ex.rs1_data;
    assign op2 = (fwd2_sel == FWD_MEM) ? mem_fwd_data :
                 (fwd2_sel == FWD_WB)  ? wb_fwd_data  : id_ex.rs2_data;

    assign src1 = id_ex.ctrl.alu_src1_pc  ? id_ex.pc  : op1;
    assign src2 = id_ex.ctrl.alu_src2_imm ? id_ex.imm : op2;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_result = src1 - src2;
            ALU_AND:    alu_result = src1 & src2;
            ALU_OR:     alu_result = src1 | src2;
            ALU_XOR:    alu_result = src1 ^ src2;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            ALU_SLL:    alu_result = src1 << src2[4:0];
            ALU_SRL:    alu_result = src1 >> src2[4:0];
            ALU_PASS_B: alu_result = src2;
            default:    alu_result = src1 + src2;
        endcase
    end

    // Compare uses forwarded registers, not ALU inputs
    always_comb begin
        case (id_ex.ctrl.br_type)
            BR_EQ:   taken = op1 == op2;
            BR_NE:   taken = op1 != op2;
            BR_LT:   taken = $signed(op1) < $signed(op2);
            default: taken = 1'b0;
        endcase
    end

    assign store_data  = op2;
    assign redirect    = taken || id_ex.ctrl.jal || id_ex.ctrl.jalr;
    // Target is pc+imm or rs1+imm
    assign redirect_pc = id_ex.ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

endmodule

`default_nettype wire

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top import cpu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [XLEN-1:0]       im_addr,
    input  logic [XLEN-1:0]       im_dout,
    output logic [XLEN-1:0]       mem_addr,
    output logic                  mem_we,
    output logic [XLEN-1:0]       mem_din,
    input  logic [XLEN-1:0]       mem_dout,
    output logic [XLEN-1:0]       current_pc,
    input  logic [REG_ADDR_W-1:0] debug_addr,
    output logic [XLEN-1:0]       debug_data
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;

    if_id_t  if_id_d;
    if_id_t  if_id_q;
    id_ex_t  id_ex_d;
    id_ex_t  id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;

    ctrl_t           id_ctrl;
    logic [XLEN-1:0] id_imm;
    logic [XLEN-1:0] id_rs1_data;
    logic [XLEN-1:0] id_rs2_data;

    fwd_sel_t        fwd1_sel;
    fwd_sel_t        fwd2_sel;
    logic [XLEN-1:0] mem_fwd_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] ex_alu_result;
    logic [XLEN-1:0] ex_store_data;
    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            ex_rs1_used;
    logic            ex_rs2_used;

    logic pc_stall;
    logic if_id_stall;
    logic if_id_flush;
    logic id_ex_flush;

    // Fetch
    assign pc_plus4 = pc + 32'd4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!pc_stall) begin
            pc <= redirect ? redirect_pc : pc_plus4;
        end
    end

    assign im_addr    = pc;
    assign current_pc = pc;
    assign if_id_d    = '{pc: pc, pc_plus4: pc_plus4, insn: im_dout};

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk    (clk),
        .reset  (reset),
        .stall  (if_id_stall),
        .flush  (if_id_flush),
        .bubble ('{pc: '0, pc_plus4: '0, insn: NOP_INSN}),
        .d      (if_id_d),
        .q      (if_id_q)
    );

    // Decode
    decoder decoder_i (
        .insn (if_id_q.insn),
        .ctrl (id_ctrl),
        .imm  (id_imm)
    );

    register_file register_file_i (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr   (if_id_q.insn[19:15]),
        .rs2_addr   (if_id_q.insn[24:20]),
        .rd_addr    (mem_wb_q.rd),
        .rd_we      (mem_wb_q.rf_we),
        .rd_data    (wb_data),
        .rs1_data   (id_rs1_data),
        .rs2_data   (id_rs2_data),
        .debug_addr (debug_addr),
        .debug_data (debug_data)
    );

    assign id_ex_d = '{
        pc:       if_id_q.pc,
        pc_plus4: if_id_q.pc_plus4,
        rs1_data: id_rs1_data,
        rs2_data: id_rs2_data,
        imm:      id_imm,
        rs1:      if_id_q.insn[19:15],
        rs2:      if_id_q.insn[24:20],
        rd:       if_id_q.insn[11:7],
        ctrl:     id_ctrl
    };

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .flush  (id_ex_flush),
        .bubble ('0),
        .d      (id_ex_d),
        .q      (id_ex_q)
    );

    // Execute
    assign ex_rs1_used = !id_ex_q.ctrl.alu_src1_pc || id_ex_q.ctrl.br_type != BR_NONE;
    assign ex_rs2_used = !id_ex_q.ctrl.alu_src2_imm || id_ex_q.ctrl.mem_we
                         || id_ex_q.ctrl.br_type != BR_NONE;

    execute execute_i (
        .id_ex        (id_ex_q),
        .fwd1_sel     (fwd1_sel),
        .fwd2_sel     (fwd2_sel),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_data  (wb_data),
        .alu_result   (ex_alu_result),
        .store_data   (ex_store_data),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

    hazard_unit hazard_unit_i (
        .ex_rs1      (id_ex_q.rs1),
        .ex_rs2      (id_ex_q.rs2),
        .ex_rs1_used (ex_rs1_used),
        .ex_rs2_used (ex_rs2_used),
        .ex_rd       (id_ex_q.rd),
        .ex_is_load  (id_ex_q.ctrl.mem_re),
        .mem_rd      (ex_mem_q.rd),
        .mem_rf_we   (ex_mem_q.rf_we),
        .mem_is_load (ex_mem_q.mem_re),
        .wb_rd       (mem_wb_q.rd),
        .wb_rf_we    (mem_wb_q.rf_we),
        .id_rs1      (if_id_q.insn[19:15]),
        .id_rs2      (if_id_q.insn[24:20]),
        .redirect    (redirect),
        .fwd1_sel    (fwd1_sel),
        .fwd2_sel    (fwd2_sel),
        .pc_stall    (pc_stall),
        .if_id_stall (if_id_stall),
        .if_id_flush (if_id_flush),
        .id_ex_flush (id_ex_flush)
    );

    assign ex_mem_d = '{
        pc_plus4:   id_ex_q.pc_plus4,
        alu:        ex_alu_result,
        store_data: ex_store_data,
        rd:         id_ex_q.rd,
        rf_we:      id_ex_q.ctrl.rf_we,
        mem_we:     id_ex_q.ctrl.mem_we,
        mem_re:     id_ex_q.ctrl.mem_re,
        wb_sel:     id_ex_q.ctrl.wb_sel
    };

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .flush  (1'b0),
        .bubble ('0),
        .d      (ex_mem_d),
        .q      (ex_mem_q)
    );

    // Memory
    assign mem_addr     = ex_mem_q.alu;
    assign mem_din      = ex_mem_q.store_data;
    assign mem_we       = ex_mem_q.mem_we;
    assign mem_fwd_data = (ex_mem_q.wb_sel == WB_PC4) ? ex_mem_q.pc_plus4 : ex_mem_q.alu;

    assign mem_wb_d = '{
        pc_plus4:  ex_mem_q.pc_plus4,
        alu:       ex_mem_q.alu,
        load_data: mem_dout,
        rd:        ex_mem_q.rd,
        rf_we:     ex_mem_q.rf_we,
        wb_sel:    ex_mem_q.wb_sel
    };

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk    (clk),
        .reset  (reset),
        .stall  (1'b0),
        .flush  (1'b0),
        .bubble ('0),
        .d      (mem_wb_d),
        .q      (mem_wb_q)
    );

    // Writeback
    always_comb begin
        case (mem_wb_q.wb_sel)
            WB_PC4:  wb_data = mem_wb_q.pc_plus4;
            WB_MEM:  wb_data = mem_wb_q.load_data;
            default: wb_data = mem_wb_q.alu;
        endcase
    end

endmodule

`default_nettype wire

//--- bench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert import cpu_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic [XLEN-1:0] im_addr,
    input logic [XLEN-1:0] mem_addr,
    input logic            mem_we,
    input logic [XLEN-1:0] current_pc
);

    // Covers every reset cycle and the first cycle after it
    no_store_in_reset: assert property (@(posedge clk) reset |=> !mem_we)
        else $error("mem_we high during or right after reset");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset) im_addr[1:0] == 2'b00)
        else $error("im_addr not word aligned");

    store_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> mem_addr[1:0] == 2'b00)
        else $error("store address not word aligned");

    pc_after_reset: assert property (@(posedge clk) reset |=> current_pc == RESET_PC)
        else $error("current_pc not at reset address after reset");

endmodule

bind cpu_top cpu_assert cpu_assert_i (
    .clk        (clk),
    .reset      (reset),
    .im_addr    (im_addr),
    .mem_addr   (mem_addr),
    .mem_we     (mem_we),
    .current_pc (current_pc)
);

`default_nettype wire

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic        clk;
    logic        reset;
    logic [31:0] im_addr;
    logic [31:0] im_dout;
    logic [31:0] mem_addr;
    logic        mem_we;
    logic [31:0] mem_din;
    logic [31:0] mem_dout;
    logic [31:0] current_pc;
    logic [4:0]  debug_addr;
    logic [31:0] debug_data;

    logic [31:0] rom [64];
    logic [31:0] ram [64];

    logic [31:0] prog [$];
    string       exp_name [$];
    logic [4:0]  exp_reg [$];
    logic [31:0] exp_value [$];
    logic [31:0] store_addr_q [$];
    logic [31:0] store_data_q [$];

    int store_idx   = 0;
    int cycle_count = 0;
    int cycle_limit;

    cpu_top uut (
        .clk        (clk),
        .reset      (reset),
        .im_addr    (im_addr),
        .im_dout    (im_dout),
        .mem_addr   (mem_addr),
        .mem_we     (mem_we),
        .mem_din    (mem_din),
        .mem_dout   (mem_dout),
        .current_pc (current_pc),
        .debug_addr (debug_addr),
        .debug_data (debug_data)
    );

    always #2 clk = ~clk;

    assign im_dout  = rom[im_addr[7:2]];
    assign mem_dout = ram[mem_addr[7:2]];

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                ram[i] <= 32'hc0de_0000 | (i << 2);  // Low half is the byte address
            end
        end else if (mem_we) begin
            ram[mem_addr[7:2]] <= mem_din;
        end
    end

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        logic [31:0] d;
        logic [31:0] s1;
        logic [31:0] s2;
        d  = rd;
        s1 = rs1;
        s2 = rs2;
        return {f7, s2[4:0], s1[4:0], f3, d[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] itype(input logic [6:0] opc, input logic [2:0] f3,
                                          input int rd, input int rs1, input int imm);
        logic [31:0] d;
        logic [31:0] s1;
        logic [31:0] v;
        d  = rd;
        s1 = rs1;
        v  = imm;
        return {v[11:0], s1[4:0], f3, d[4:0], opc};
    endfunction

    // sw rs2, imm(rs1)
    function automatic logic [31:0] stype(input int rs2, input int rs1, input int imm);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] v;
        s1 = rs1;
        s2 = rs2;
        v  = imm;
        return {v[11:5], s2[4:0], s1[4:0], 3'b010, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [2:0] f3, input int rs1, input int rs2,
                                          input int imm);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] v;
        s1 = rs1;
        s2 = rs2;
        v  = imm;
        return {v[12], v[10:5], s2[4:0], s1[4:0], f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] utype(input int rd, input int imm20);
        logic [31:0] d;
        logic [31:0] v;
        d = rd;
        v = imm20;
        return {v[19:0], d[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] jtype(input int rd, input int imm);
        logic [31:0] d;
        logic [31:0] v;
        d = rd;
        v = imm;
        return {v[20], v[10:1], v[11], v[19:12], d[4:0], 7'b1101111};
    endfunction

    task automatic expect_reg(input string name, input logic [4:0] r, input logic [31:0] v);
        exp_name.push_back(name);
        exp_reg.push_back(r);
        exp_value.push_back(v);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    // Each sw must match the next table entry
    always @(negedge clk) begin
        if (!reset && mem_we) begin
            if (store_idx >= store_addr_q.size()) begin
                $display("Unexpected store to address %h", mem_addr);
                $display("Checks failed");
                $fatal(1);
            end else begin
                check_value($sformatf("sw %0d address", store_idx), store_addr_q[store_idx],
                            mem_addr);
                check_value($sformatf("sw %0d data", store_idx), store_data_q[store_idx],
                            mem_din);
                store_idx++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Program did not finish within %0d cycles", cycle_limit);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        logic [31:0] final_pc;
        int          final_hits;
        clk        = 1'b0;
        reset      = 1'b1;
        debug_addr = '0;
        final_hits = 0;

        prog.push_back(itype(7'b0010011, 3'b000, 1, 0, 5));     // addi x1, x0, 5
        prog.push_back(itype(7'b0010011, 3'b000, 2, 0, 12));    // addi x2, x0, 12
        prog.push_back(rtype(7'h00, 3'b000, 3, 1, 2));          // add x3, x1, x2
        prog.push_back(rtype(7'h20, 3'b000, 4, 1, 3));          // sub x4, x1, x3
        prog.push_back(rtype(7'h00, 3'b010, 5, 4, 1));          // slt x5, x4, x1
        prog.push_back(rtype(7'h00, 3'b001, 6, 3, 5));          // sll x6, x3, x5
        prog.push_back(rtype(7'h00, 3'b101, 7, 4, 1));          // srl x7, x4, x1
        prog.push_back(utype(8, 'h12345));                      // lui x8, 0x12345
        prog.push_back(itype(7'b0010011, 3'b110, 8, 8, 'h678)); // ori x8, x8, 0x678
        prog.push_back(rtype(7'h00, 3'b100, 9, 8, 6));          // xor x9, x8, x6
        prog.push_back(itype(7'b0010011, 3'b111, 10, 9, 'hff)); // andi x10, x9, 0xff
        prog.push_back(itype(7'b0010011, 3'b001, 11, 10, 4));   // slli x11, x10, 4
        prog.push_back(itype(7'b0010011, 3'b101, 12, 11, 2));   // srli x12, x11, 2
        prog.push_back(rtype(7'h00, 3'b110, 13, 12, 1));        // or x13, x12, x1
        prog.push_back(rtype(7'h00, 3'b111, 14, 13, 2));        // and x14, x13, x2
        prog.push_back(itype(7'b0010011, 3'b100, 15, 14, -1));  // xori x15, x14, -1
        prog.push_back(stype(8, 0, 16));                        // sw x8, 16(x0)
        prog.push_back(stype(15, 2, 8));                        // sw x15, 8(x2)
        prog.push_back(itype(7'b0000011, 3'b010, 16, 0, 16));   // lw x16, 16(x0)
        prog.push_back(rtype(7'h00, 3'b000, 17, 16, 1));        // add x17, x16, x1
        prog.push_back(itype(7'b0000011, 3'b010, 18, 2, 16));   // lw x18, 16(x2)
        prog.push_back(rtype(7'h00, 3'b000, 19, 1, 18));        // add x19, x1, x18
        prog.push_back(btype(3'b000, 1, 5, 8));                 // beq x1, x5 not taken
        prog.push_back(itype(7'b0010011, 3'b000, 20, 0, 1));
        prog.push_back(btype(3'b001, 3, 4, 12));                // bne x3, x4 taken
        prog.push_back(itype(7'b0010011, 3'b000, 21, 0, 1));
        prog.push_back(itype(7'b0010011, 3'b000, 22, 0, 1));
        prog.push_back(btype(3'b100, 4, 1, 8));                 // blt x4, x1 taken
        prog.push_back(itype(7'b0010011, 3'b000, 23, 0, 1));
        prog.push_back(btype(3'b100, 1, 4, 8));                 // blt x1, x4 not taken
        prog.push_back(itype(7'b0010011, 3'b000, 24, 0, 1));
        prog.push_back(btype(3'b000, 14, 2, 8));                // beq x14, x2 taken
        prog.push_back(itype(7'b0010011, 3'b000, 25, 0, 1));
        prog.push_back(btype(3'b001, 14, 2, 8));                // bne x14, x2 not taken
        prog.push_back(itype(7'b0010011, 3'b000, 26, 0, 7));
        prog.push_back(jtype(27, 8));                           // jal x27, +8
        prog.push_back(itype(7'b0010011, 3'b000, 28, 0, 1));
        prog.push_back(itype(7'b0010011, 3'b000, 29, 0, 161));  // Odd jalr target
        prog.push_back(itype(7'b1100111, 3'b000, 30, 29, 0));   // jalr x30, 0(x29)
        prog.push_back(itype(7'b0010011, 3'b000, 28, 0, 2));
        prog.push_back(rtype(7'h00, 3'b000, 31, 27, 30));       // add x31, x27, x30
        prog.push_back(itype(7'b0010011, 3'b000, 0, 1, 99));    // addi x0, x1, 99
        prog.push_back(rtype(7'h00, 3'b000, 10, 0, 1));         // add x10, x0, x1
        prog.push_back(jtype(0, 0));                            // Final self-loop

        store_addr_q.push_back(32'd16);
        store_data_q.push_back(32'h1234_5678);
        store_addr_q.push_back(32'd20);
        store_data_q.push_back(32'hffff_fff3);

        expect_reg("x0 stays zero", 5'd0, 32'h0);
        expect_reg("addi x1", 5'd1, 32'd5);
        expect_reg("addi x2", 5'd2, 32'd12);
        expect_reg("add x3", 5'd3, 32'd17);
        expect_reg("sub x4", 5'd4, 32'hffff_fff4);
        expect_reg("slt x5", 5'd5, 32'd1);
        expect_reg("sll x6", 5'd6, 32'd34);
        expect_reg("srl x7", 5'd7, 32'h07ff_ffff);
        expect_reg("lui ori x8", 5'd8, 32'h1234_5678);
        expect_reg("xor x9", 5'd9, 32'h1234_565a);
        expect_reg("x0 read x10", 5'd10, 32'd5);
        expect_reg("slli x11", 5'd11, 32'h5a0);
        expect_reg("srli x12", 5'd12, 32'h168);
        expect_reg("or x13", 5'd13, 32'h16d);
        expect_reg("and x14", 5'd14, 32'hc);
        expect_reg("xori x15", 5'd15, 32'hffff_fff3);
        expect_reg("lw x16", 5'd16, 32'h1234_5678);
        expect_reg("load use x17", 5'd17, 32'h1234_567d);
        expect_reg("lw x18", 5'd18, 32'hc0de_001c);
        expect_reg("load use x19", 5'd19, 32'hc0de_0021);
        expect_reg("beq untaken x20", 5'd20, 32'd1);
        expect_reg("bne shadow x21", 5'd21, 32'd0);
        expect_reg("bne shadow x22", 5'd22, 32'd0);
        expect_reg("blt shadow x23", 5'd23, 32'd0);
        expect_reg("blt untaken x24", 5'd24, 32'd1);
        expect_reg("beq shadow x25", 5'd25, 32'd0);
        expect_reg("bne untaken x26", 5'd26, 32'd7);
        expect_reg("jal link x27", 5'd27, 32'd144);
        expect_reg("jump shadow x28", 5'd28, 32'd0);
        expect_reg("addi x29", 5'd29, 32'd161);
        expect_reg("jalr link x30", 5'd30, 32'd156);
        expect_reg("jump sum x31", 5'd31, 32'd300);

        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < prog.size()) ? prog[i] : 32'h0000_0013;
        end
        cycle_limit = 4 * prog.size() + 40;
        final_pc    = (prog.size() - 1) * 4;

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Third visit means the pipeline has drained
        while (final_hits < 3) begin
            @(negedge clk);
            if (current_pc == final_pc) begin
                final_hits++;
            end
        end

        for (int i = 0; i < exp_name.size(); i++) begin
            @(negedge clk);
            debug_addr = exp_reg[i];
            @(negedge clk);
            check_value(exp_name[i], exp_value[i], debug_data);
        end
        check_value("store count", store_addr_q.size(), store_idx);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/cpu_pkg.sv
logic/stage_reg.sv
logic/decoder.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute.sv
logic/cpu_top.sv
bench/cpu_assert.sv
bench/cpu_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --top-module cpu_tb -f vlog.f -o cpu_sim &&
./obj_dir/cpu_sim | tee /dev/stderr | grep -q "All checks passed" || exit 1
